/* tb.f */
chimera_dbg_pkg.sv
jtag_tap.sv
dm_sysbus.sv
sb_mem.sv
chimera_dbg_top.sv
tb_clk_gen.sv
tb_chimera_dbg_assert.sv
tb_chimera_dbg.sv

/* Bender.yml */
package:
  name: chimera_dbg

sources:
  - files:
      - chimera_dbg_pkg.sv
      - jtag_tap.sv
      - dm_sysbus.sv
      - sb_mem.sv
      - chimera_dbg_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_chimera_dbg_assert.sv
      - tb_chimera_dbg.sv

/* tb_chimera_dbg.sv */
`timescale 1ns/1ps

module tb_chimera_dbg import chimera_dbg_pkg::*; ();

  localparam logic [31:0] IdCode    = 32'h1c5e_5db3;
  localparam int unsigned SbCredits = 2;
  localparam int unsigned MemWords  = 256;
  localparam int unsigned NumSingle = 6;
  localparam int unsigned NumBurst  = 8;
  localparam int unsigned MaxPolls  = 4;
  // Upper bound on scans, every poll loop counted at its limit
  localparam int unsigned NumScans  = 24 + NumSingle * (5 + 2 * MaxPolls) + NumBurst * 3 +
                                      10 * (2 + 2 * MaxPolls);

  logic jtag_tck, arst_n, tms, tdi, tdo;

  // Reference state of the debug registers and the memory
  logic [31:0] model_mem [MemWords];
  logic        m_dmactive;
  sbcs_t       m_sbcs;
  logic [31:0] m_sbaddr, m_sbdata, lfsr;
  int unsigned checks;

  dmi_rsp_t    rsp_act_q[$], rsp_exp_q[$];
  string       rsp_name_q[$];
  sbcs_t       sbcs_act_q[$], sbcs_exp_q[$];
  logic [31:0] word_act_q[$], word_exp_q[$];
  string       word_name_q[$];

  tb_clk_gen #(
    .PeriodNs   (100),
    .ResetCycles(4)
  ) i_clk_gen (
    .jtag_tck_o(jtag_tck),
    .arst_n_o  (arst_n)
  );

  chimera_dbg_top #(
    .IdCode   (IdCode),
    .SbCredits(SbCredits),
    .MemWords (MemWords)
  ) dut0 (
    .jtag_tck(jtag_tck),
    .arst_n_i(arst_n),
    .tms_i   (tms),
    .tdi_i   (tdi),
    .tdo_o   (tdo)
  );

  ////////////////////
  // Checking
  ////////////////////

  task automatic fail_stop(input string why);
    $display("ERROR %0t: %s", $time, why);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_rsp(input string name, input dmi_rsp_t act, input dmi_rsp_t exp);
    checks++;
    if (act !== exp) begin
      $display("FAIL %0t %s: got %h expected %h", $time, name, act, exp);
      fail_stop("DMI read response mismatch");
    end
  endtask

  task automatic compare_sbcs(input sbcs_t act, input sbcs_t exp);
    checks++;
    if (act !== exp) begin
      $display("FAIL %0t sbcs: got %h expected %h", $time, act, exp);
      fail_stop("SBCS value mismatch");
    end
  endtask

  task automatic compare_word(input string name, input logic [31:0] act,
                              input logic [31:0] exp);
    checks++;
    if (act !== exp) begin
      $display("FAIL %0t %s: got %h expected %h", $time, name, act, exp);
      fail_stop("scanned word mismatch");
    end
  endtask

  initial begin : compare_proc
    forever begin
      @(posedge jtag_tck);
      while (rsp_act_q.size() > 0) begin
        compare_rsp(rsp_name_q.pop_front(), rsp_act_q.pop_front(), rsp_exp_q.pop_front());
      end
      while (sbcs_act_q.size() > 0) begin
        compare_sbcs(sbcs_act_q.pop_front(), sbcs_exp_q.pop_front());
      end
      while (word_act_q.size() > 0) begin
        compare_word(word_name_q.pop_front(), word_act_q.pop_front(), word_exp_q.pop_front());
      end
    end
  end

  always @(posedge jtag_tck) begin
    if (dut0.i_dm_sysbus.i_sysbus_assert.failures != 0) begin
      fail_stop("assertion on dm_sysbus failed");
    end
  end

  initial begin : watchdog
    repeat (NumScans * 60) @(posedge jtag_tck);
    fail_stop("watchdog expired before the tests finished");
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    int unsigned i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic dmi_rsp_t expected_read(input logic [6:0] addr);
    dmi_rsp_t r;
    r.resp = DmiSuccess;
    case (addr)
      DmiAddrDmControl:  r.data = {31'b0, m_dmactive};
      DmiAddrSbcs:       r.data = m_sbcs;
      DmiAddrSbAddress0: r.data = m_sbaddr;
      DmiAddrSbData0:    r.data = m_sbdata;
      default:           r.data = '0;
    endcase
    return r;
  endfunction

  function automatic logic [31:0] sbcs_word(input logic rdonaddr, input logic [2:0] access,
                                            input logic autoinc, input logic rdondata,
                                            input logic [2:0] err);
    sbcs_t s;
    s = '0;
    s.sbreadonaddr    = rdonaddr;
    s.sbaccess        = access;
    s.sbautoincrement = autoinc;
    s.sbreadondata    = rdondata;
    s.sberror         = err;
    return s;
  endfunction

  // One bus access as the debug spec defines it
  task automatic model_access(input logic we);
    logic [29:0] word;
    word = m_sbaddr[31:2];
    if (m_sbcs.sberror == SberrNone) begin
      if (m_sbcs.sbaccess != SbAccess32) begin
        m_sbcs.sberror = SberrBadSize;
      end else begin
        if (word >= MemWords) begin
          m_sbcs.sberror = SberrBadAddr;
        end else if (we) begin
          model_mem[word] = m_sbdata;
        end else begin
          m_sbdata = model_mem[word];
        end
        if (m_sbcs.sbautoincrement) begin
          m_sbaddr = m_sbaddr + 32'd4;
        end
      end
    end
  endtask

  task automatic model_write(input logic [6:0] addr, input logic [31:0] data);
    sbcs_t w;
    w = data;
    case (addr)
      DmiAddrDmControl: m_dmactive = data[0];
      DmiAddrSbcs: begin
        m_sbcs.sbreadonaddr    = w.sbreadonaddr;
        m_sbcs.sbaccess        = w.sbaccess;
        m_sbcs.sbautoincrement = w.sbautoincrement;
        m_sbcs.sbreadondata    = w.sbreadondata;
        m_sbcs.sberror         = m_sbcs.sberror & ~w.sberror;
      end
      DmiAddrSbAddress0: begin
        m_sbaddr = data;
        if (m_sbcs.sbreadonaddr) begin
          model_access(1'b0);
        end
      end
      DmiAddrSbData0: begin
        m_sbdata = data;
        model_access(1'b1);
      end
      default: ;
    endcase
  endtask

  ////////////////////
  // JTAG driver
  ////////////////////

  // Called right after a rising edge, TDO belongs to the current state
  task automatic tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
    tms <= tms_v;
    tdi <= tdi_v;
    @(posedge jtag_tck);
    tdo_v = tdo;
  endtask

  task automatic scan_ir(input logic [IrLength-1:0] ir);
    logic        tdo_bit;
    int unsigned i;
    tck_cycle(1'b1, 1'b0, tdo_bit);
    tck_cycle(1'b1, 1'b0, tdo_bit);
    tck_cycle(1'b0, 1'b0, tdo_bit);
    tck_cycle(1'b0, 1'b0, tdo_bit);
    for (i = 0; i < IrLength; i++) begin
      tck_cycle(i == IrLength - 1, ir[i], tdo_bit);
    end
    tck_cycle(1'b1, 1'b0, tdo_bit);
    tck_cycle(1'b0, 1'b0, tdo_bit);
  endtask

  task automatic scan_dr(input logic [63:0] din, input int unsigned len,
                         output logic [63:0] dout);
    logic        tdo_bit;
    int unsigned i;
    dout = '0;
    tck_cycle(1'b1, 1'b0, tdo_bit);
    tck_cycle(1'b0, 1'b0, tdo_bit);
    tck_cycle(1'b0, 1'b0, tdo_bit);
    for (i = 0; i < len; i++) begin
      tck_cycle(i == len - 1, din[i], tdo_bit);
      dout[i] = tdo_bit;
    end
    tck_cycle(1'b1, 1'b0, tdo_bit);
    tck_cycle(1'b0, 1'b0, tdo_bit);
  endtask

  // Each scan returns the response to the previous request
  task automatic dmi_scan(input logic [6:0] addr, input logic [31:0] data, input dmi_op_e op,
                          output dmi_rsp_t prev);
    dmi_req_t    req;
    logic [63:0] dout;
    req.addr = addr;
    req.data = data;
    req.op   = op;
    scan_dr({{(64 - $bits(dmi_req_t)){1'b0}}, req}, $bits(dmi_req_t), dout);
    prev = dout[$bits(dmi_rsp_t)-1:0];
  endtask

  task automatic dmi_write(input logic [6:0] addr, input logic [31:0] data);
    dmi_rsp_t prev;
    dmi_scan(addr, data, DmiWrite, prev);
    model_write(addr, data);
  endtask

  task automatic dmi_read(input logic [6:0] addr, output dmi_rsp_t rsp);
    dmi_rsp_t prev;
    dmi_scan(addr, 32'h0, DmiRead, prev);
    dmi_scan(7'h0, 32'h0, DmiNop, rsp);
  endtask

  task automatic check_read(input string name, input logic [6:0] addr);
    dmi_rsp_t exp, act;
    exp = expected_read(addr);
    dmi_read(addr, act);
    rsp_name_q.push_back(name);
    rsp_act_q.push_back(act);
    rsp_exp_q.push_back(exp);
    if (addr == DmiAddrSbData0 && m_sbcs.sbreadondata) begin
      model_access(1'b0);
    end
  endtask

  task automatic poll_sbcs();
    dmi_rsp_t    rsp, exp;
    sbcs_t       s;
    int unsigned n;
    n = 0;
    do begin
      dmi_read(DmiAddrSbcs, rsp);
      s = rsp.data;
      n++;
      if (n > MaxPolls) begin
        fail_stop("sbbusy did not clear while polling SBCS");
      end
    end while (rsp.resp != DmiSuccess || s.sbbusy);
    exp = expected_read(DmiAddrSbcs);
    sbcs_act_q.push_back(s);
    sbcs_exp_q.push_back(exp.data);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin : stimulus
    logic [63:0] dout;
    logic [31:0] din, base, a;
    int unsigned k;
    tms        = 1'b1;
    tdi        = 1'b0;
    lfsr       = 32'h49d2_4f45;
    checks     = 0;
    m_dmactive = 1'b0;
    m_sbcs     = '0;
    m_sbcs.sbaccess = SbAccess32;
    m_sbaddr   = 'x;
    m_sbdata   = 'x;
    wait (arst_n === 1'b1);
    @(posedge jtag_tck);
    tck_cycle(1'b0, 1'b0, din[0]);

    // IDCODE selected by reset
    scan_dr(64'h0, 32, dout);
    word_name_q.push_back("tdo_o idcode");
    word_act_q.push_back(dout[31:0]);
    word_exp_q.push_back(IdCode);

    // BYPASS delays TDI by one shift
    scan_ir(IrBypass);
    din = rand_bits(32);
    scan_dr({32'h0, din}, 32, dout);
    word_name_q.push_back("tdo_o bypass");
    word_act_q.push_back(dout[31:0]);
    word_exp_q.push_back({din[30:0], 1'b0});

    scan_ir(IrDmi);
    poll_sbcs();
    dmi_write(DmiAddrDmControl, 32'h1);
    check_read("dmi_rsp dmcontrol", DmiAddrDmControl);

    // Single writes read back through sbreadonaddr
    dmi_write(DmiAddrSbcs, sbcs_word(1'b1, SbAccess32, 1'b0, 1'b0, 3'b0));
    for (k = 0; k < NumSingle; k++) begin
      a = rand_bits(8);
      dmi_write(DmiAddrSbAddress0, a << 2);
      dmi_write(DmiAddrSbData0, rand_bits(32));
      dmi_write(DmiAddrSbAddress0, a << 2);
      poll_sbcs();
      check_read("dmi_rsp sbdata0 single", DmiAddrSbData0);
    end

    // Posted burst, then sbreadondata burst
    base = rand_bits(7) << 2;
    dmi_write(DmiAddrSbcs, sbcs_word(1'b0, SbAccess32, 1'b1, 1'b0, 3'b0));
    dmi_write(DmiAddrSbAddress0, base);
    for (k = 0; k < NumBurst; k++) begin
      dmi_write(DmiAddrSbData0, rand_bits(32));
    end
    poll_sbcs();
    check_read("dmi_rsp sbaddress0 burst end", DmiAddrSbAddress0);
    dmi_write(DmiAddrSbcs, sbcs_word(1'b1, SbAccess32, 1'b1, 1'b1, 3'b0));
    dmi_write(DmiAddrSbAddress0, base);
    poll_sbcs();
    for (k = 0; k < NumBurst; k++) begin
      check_read("dmi_rsp sbdata0 burst", DmiAddrSbData0);
    end

    // Bad size, clear, bad address, blocked write, clear
    dmi_write(DmiAddrSbcs, sbcs_word(1'b0, 3'd0, 1'b0, 1'b0, 3'b0));
    dmi_write(DmiAddrSbData0, rand_bits(32));
    poll_sbcs();
    dmi_write(DmiAddrSbcs, sbcs_word(1'b1, SbAccess32, 1'b0, 1'b0, 3'b111));
    poll_sbcs();
    dmi_write(DmiAddrSbAddress0, MemWords * 4);
    poll_sbcs();
    dmi_write(DmiAddrSbAddress0, base);
    dmi_write(DmiAddrSbData0, ~model_mem[base[31:2]]);
    dmi_write(DmiAddrSbcs, sbcs_word(1'b1, SbAccess32, 1'b0, 1'b0, 3'b111));
    poll_sbcs();
    dmi_write(DmiAddrSbAddress0, base);
    poll_sbcs();
    check_read("dmi_rsp sbdata0 after blocked write", DmiAddrSbData0);

    repeat (2) @(posedge jtag_tck);
    if (checks > 0 && rsp_act_q.size() == 0 && sbcs_act_q.size() == 0 &&
        word_act_q.size() == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      fail_stop("queued checks were not all compared");
    end
  end

endmodule

/* tb_chimera_dbg_assert.sv */
`timescale 1ns/1ps

module tb_chimera_dbg_assert import chimera_dbg_pkg::*; #(
  parameter int unsigned SbCredits = 2,
  parameter int unsigned CntW      = 2
) (
  input logic            jtag_tck,
  input logic            arst_n_i,
  input logic [CntW-1:0] credits_i,
  input logic            sb_req_valid_i,
  input sb_req_t         sb_req_i,
  input logic            sb_credit_i,
  input logic            sb_rsp_valid_i,
  input logic            sbbusy_i
);

  int unsigned failures = 0;

  // Credits in use and responses still owed, as seen on the bus
  int unsigned used_q, owed_q;
  logic        rd_wait_q;

  // Reads block new accesses, so the read is always the last response owed
  always_ff @(posedge jtag_tck or negedge arst_n_i) begin
    if (!arst_n_i) begin
      used_q    <= 0;
      owed_q    <= 0;
      rd_wait_q <= 1'b0;
    end else begin
      used_q <= used_q + 32'(sb_req_valid_i) - 32'(sb_credit_i);
      owed_q <= owed_q + 32'(sb_req_valid_i) - 32'(sb_rsp_valid_i);
      if (sb_req_valid_i && !sb_req_i.we) begin
        rd_wait_q <= 1'b1;
      end else if (sb_rsp_valid_i && (owed_q == 1)) begin
        rd_wait_q <= 1'b0;
      end
    end
  end

  credit_limit: assert property (@(posedge jtag_tck) disable iff (!arst_n_i)
    credits_i <= CntW'(SbCredits))
    else begin
      failures++;
      $error("credit counter above %0d", SbCredits);
    end

  // A request always spends a credit that exists
  req_needs_credit: assert property (@(posedge jtag_tck) disable iff (!arst_n_i)
    sb_req_valid_i |-> (used_q < SbCredits))
    else begin
      failures++;
      $error("system bus request issued without a credit");
    end

  busy_on_read: assert property (@(posedge jtag_tck) disable iff (!arst_n_i)
    rd_wait_q |-> sbbusy_i)
    else begin
      failures++;
      $error("sbbusy low while a read is outstanding");
    end

endmodule

bind dm_sysbus tb_chimera_dbg_assert #(
  .SbCredits(SbCredits),
  .CntW     (CntW)
) i_sysbus_assert (
  .jtag_tck      (jtag_tck),
  .arst_n_i      (arst_n_i),
  .credits_i     (credits_q),
  .sb_req_valid_i(sb_req_valid_o),
  .sb_req_i      (sb_req_o),
  .sb_credit_i   (sb_credit_i),
  .sb_rsp_valid_i(sb_rsp_valid_i),
  .sbbusy_i      (sbbusy)
);

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 100,
  parameter int unsigned ResetCycles = 4
) (
  output logic jtag_tck_o,
  output logic arst_n_o
);

  initial begin
    jtag_tck_o = 1'b0;
    forever #(PeriodNs / 2) jtag_tck_o = ~jtag_tck_o;
  end

  // Release on a falling edge, clear of the sampling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge jtag_tck_o);
    @(negedge jtag_tck_o);
    arst_n_o = 1'b1;
  end

endmodule

/* chimera_dbg_top.sv */
`timescale 1ns/1ps

module chimera_dbg_top import chimera_dbg_pkg::*; #(
  parameter logic [31:0] IdCode    = 32'h1c5e_5db3,
  parameter int unsigned SbCredits = 2,
  parameter int unsigned MemWords  = 256
) (
  input  logic jtag_tck,
  input  logic arst_n_i,
  input  logic tms_i,
  input  logic tdi_i,
  output logic tdo_o
);

  logic     dmi_req_valid, dmi_rsp_valid;
  dmi_req_t dmi_req;
  dmi_rsp_t dmi_rsp;
  logic     sb_req_valid, sb_credit, sb_rsp_valid;
  sb_req_t  sb_req;
  sb_rsp_t  sb_rsp;

  ////////////////////
  // JTAG side
  ////////////////////

  jtag_tap #(
    .IdCode(IdCode)
  ) i_jtag_tap (
    .jtag_tck       (jtag_tck),
    .arst_n_i       (arst_n_i),
    .tms_i          (tms_i),
    .tdi_i          (tdi_i),
    .tdo_o          (tdo_o),
    .dmi_req_valid_o(dmi_req_valid),
    .dmi_req_o      (dmi_req),
    .dmi_rsp_valid_i(dmi_rsp_valid),
    .dmi_rsp_i      (dmi_rsp)
  );

  ////////////////////
  // System bus side
  ////////////////////

  dm_sysbus #(
    .SbCredits(SbCredits)
  ) i_dm_sysbus (
    .jtag_tck       (jtag_tck),
    .arst_n_i       (arst_n_i),
    .dmi_req_valid_i(dmi_req_valid),
    .dmi_req_i      (dmi_req),
    .dmi_rsp_valid_o(dmi_rsp_valid),
    .dmi_rsp_o      (dmi_rsp),
    .sb_req_valid_o (sb_req_valid),
    .sb_req_o       (sb_req),
    .sb_credit_i    (sb_credit),
    .sb_rsp_valid_i (sb_rsp_valid),
    .sb_rsp_i       (sb_rsp)
  );

  // Memory also sizes its request queue from the credit count
  sb_mem #(
    .SbCredits(SbCredits),
    .MemWords (MemWords)
  ) i_sb_mem (
    .jtag_tck      (jtag_tck),
    .arst_n_i      (arst_n_i),
    .sb_req_valid_i(sb_req_valid),
    .sb_req_i      (sb_req),
    .sb_credit_o   (sb_credit),
    .sb_rsp_valid_o(sb_rsp_valid),
    .sb_rsp_o      (sb_rsp)
  );

endmodule

/* sb_mem.sv */
`timescale 1ns/1ps

module sb_mem import chimera_dbg_pkg::*; #(
  parameter int unsigned SbCredits = 2,
  parameter int unsigned MemWords  = 256
) (
  input  logic    jtag_tck,
  input  logic    arst_n_i,
  input  logic    sb_req_valid_i,
  input  sb_req_t sb_req_i,
  output logic    sb_credit_o,
  output logic    sb_rsp_valid_o,
  output sb_rsp_t sb_rsp_o
);

  localparam int unsigned PtrW  = (SbCredits > 1) ? $clog2(SbCredits) : 1;
  localparam int unsigned CntW  = $clog2(SbCredits + 1);
  localparam int unsigned MemAw = (MemWords > 1) ? $clog2(MemWords) : 1;

  sb_req_t         queue_q [SbCredits];
  logic [31:0]     mem_q [MemWords];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            gap_q, pop, in_range;
  sb_req_t         head;

  // At most one pop every second cycle
  assign pop         = (count_q != '0) && !gap_q;
  assign sb_credit_o = pop;
  assign head        = queue_q[rd_ptr_q];
  assign in_range    = head.addr < 30'(MemWords);

  always_ff @(posedge jtag_tck or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q       <= '0;
      rd_ptr_q       <= '0;
      count_q        <= '0;
      gap_q          <= 1'b0;
      sb_rsp_valid_o <= 1'b0;
    end else begin
      gap_q          <= pop;
      sb_rsp_valid_o <= pop;
      count_q        <= count_q + CntW'(sb_req_valid_i) - CntW'(pop);
      if (sb_req_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(SbCredits - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(SbCredits - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // Queue storage and memory array
  always_ff @(posedge jtag_tck) begin
    if (sb_req_valid_i) begin
      queue_q[wr_ptr_q] <= sb_req_i;
    end
    if (pop) begin
      if (head.we && in_range) begin
        mem_q[head.addr[MemAw-1:0]] <= head.wdata;
      end
      sb_rsp_o.rdata <= in_range ? mem_q[head.addr[MemAw-1:0]] : '0;
      sb_rsp_o.err   <= !in_range;
    end
  end

endmodule

/* dm_sysbus.sv */
`timescale 1ns/1ps

module dm_sysbus import chimera_dbg_pkg::*; #(
  parameter int unsigned SbCredits = 2
) (
  input  logic     jtag_tck,
  input  logic     arst_n_i,
  input  logic     dmi_req_valid_i,
  input  dmi_req_t dmi_req_i,
  output logic     dmi_rsp_valid_o,
  output dmi_rsp_t dmi_rsp_o,
  output logic     sb_req_valid_o,
  output sb_req_t  sb_req_o,
  input  logic     sb_credit_i,
  input  logic     sb_rsp_valid_i,
  input  sb_rsp_t  sb_rsp_i
);

  localparam int unsigned CntW = $clog2(SbCredits + 2);

  logic            dmactive_q;
  logic            readonaddr_q, autoinc_q, readondata_q;
  logic [2:0]      sbaccess_q, sberror_q;
  logic [CntW-1:0] credits_q, out_q;
  logic            acc_pend_q, acc_we_q, rd_pend_q, busy_sticky_q;
  logic [31:0]     sbaddr_q, sbdata_q, rd_data;
  dmi_word_u       wr_word;
  sbcs_t           sbcs_rd;
  logic            sbbusy, access_busy, is_rd, is_wr, req_busy, req_ok;
  logic            wr_ctrl, wr_sbcs, wr_addr, wr_data, start_rd, start_wr;
  logic            issue, rsp_is_rd;

  ////////////////////
  // DMI decode
  ////////////////////

  assign wr_word.raw = dmi_req_i.data;

  // Access in flight, either waiting for a credit or a read outstanding
  assign access_busy = rd_pend_q | acc_pend_q;
  assign sbbusy      = access_busy | (credits_q == '0);

  assign is_rd    = dmi_req_valid_i && (dmi_req_i.op == DmiRead);
  assign is_wr    = dmi_req_valid_i && (dmi_req_i.op == DmiWrite);
  assign req_busy = (is_rd | is_wr) & (busy_sticky_q | access_busy);
  assign req_ok   = (is_rd | is_wr) & ~req_busy;

  assign wr_ctrl = req_ok && is_wr && (dmi_req_i.addr == DmiAddrDmControl);
  assign wr_sbcs = req_ok && is_wr && (dmi_req_i.addr == DmiAddrSbcs);
  assign wr_addr = req_ok && is_wr && (dmi_req_i.addr == DmiAddrSbAddress0);
  assign wr_data = req_ok && is_wr && (dmi_req_i.addr == DmiAddrSbData0);

  assign start_rd = (wr_addr && readonaddr_q) ||
                    (req_ok && is_rd && (dmi_req_i.addr == DmiAddrSbData0) && readondata_q);
  assign start_wr = wr_data;

  assign sbcs_rd = '{
    sbbusy:          sbbusy,
    sbreadonaddr:    readonaddr_q,
    sbaccess:        sbaccess_q,
    sbautoincrement: autoinc_q,
    sbreadondata:    readondata_q,
    sberror:         sberror_q,
    default:         '0
  };

  always_comb begin
    case (dmi_req_i.addr)
      DmiAddrDmControl:  rd_data = {31'b0, dmactive_q};
      DmiAddrSbcs:       rd_data = sbcs_rd;
      DmiAddrSbAddress0: rd_data = sbaddr_q;
      DmiAddrSbData0:    rd_data = sbdata_q;
      default:           rd_data = '0;
    endcase
  end

  ////////////////////
  // System bus master
  ////////////////////

  assign issue          = acc_pend_q && (credits_q != '0);
  assign sb_req_valid_o = issue;
  assign sb_req_o       = '{we: acc_we_q, addr: sbaddr_q[31:2], wdata: sbdata_q};

  // Responses come in order, so the read is the last one outstanding
  assign rsp_is_rd = sb_rsp_valid_i && rd_pend_q && (out_q == CntW'(1));

  always_ff @(posedge jtag_tck or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dmactive_q      <= 1'b0;
      readonaddr_q    <= 1'b0;
      autoinc_q       <= 1'b0;
      readondata_q    <= 1'b0;
      sbaccess_q      <= SbAccess32;
      sberror_q       <= SberrNone;
      credits_q       <= CntW'(SbCredits);
      out_q           <= '0;
      acc_pend_q      <= 1'b0;
      acc_we_q        <= 1'b0;
      rd_pend_q       <= 1'b0;
      busy_sticky_q   <= 1'b0;
      dmi_rsp_valid_o <= 1'b0;
    end else begin
      dmi_rsp_valid_o <= dmi_req_valid_i;
      // Busy stays until the host sends a nop
      if (dmi_req_valid_i && (dmi_req_i.op == DmiNop)) begin
        busy_sticky_q <= 1'b0;
      end else if (req_busy) begin
        busy_sticky_q <= 1'b1;
      end
      if (wr_ctrl) begin
        dmactive_q <= dmi_req_i.data[0];
      end
      if (wr_sbcs) begin
        readonaddr_q <= wr_word.sbcs.sbreadonaddr;
        sbaccess_q   <= wr_word.sbcs.sbaccess;
        autoinc_q    <= wr_word.sbcs.sbautoincrement;
        readondata_q <= wr_word.sbcs.sbreadondata;
        // Write one to clear
        sberror_q    <= sberror_q & ~wr_word.sbcs.sberror;
      end
      if ((start_rd || start_wr) && (sberror_q == SberrNone)) begin
        if (sbaccess_q != SbAccess32) begin
          sberror_q <= SberrBadSize;
        end else begin
          acc_pend_q <= 1'b1;
          acc_we_q   <= start_wr;
        end
      end
      if (issue) begin
        acc_pend_q <= 1'b0;
        rd_pend_q  <= ~acc_we_q;
      end
      if (rsp_is_rd) begin
        rd_pend_q <= 1'b0;
      end
      if (sb_rsp_valid_i && sb_rsp_i.err) begin
        sberror_q <= SberrBadAddr;
      end
      credits_q <= credits_q - CntW'(issue) + CntW'(sb_credit_i);
      out_q     <= out_q + CntW'(issue) - CntW'(sb_rsp_valid_i);
    end
  end

  always_ff @(posedge jtag_tck) begin
    dmi_rsp_o.data <= rd_data;
    dmi_rsp_o.resp <= req_busy ? DmiBusy : DmiSuccess;
    if (wr_addr) begin
      sbaddr_q <= dmi_req_i.data;
    end else if (issue && autoinc_q) begin
      sbaddr_q <= sbaddr_q + 32'd4;
    end
    if (wr_data) begin
      sbdata_q <= dmi_req_i.data;
    end else if (rsp_is_rd && !sb_rsp_i.err) begin
      sbdata_q <= sb_rsp_i.rdata;
    end
  end

endmodule

/* jtag_tap.sv */
`timescale 1ns/1ps

module jtag_tap import chimera_dbg_pkg::*; #(
  parameter logic [31:0] IdCode = 32'h0000_0001
) (
  input  logic     jtag_tck,
  input  logic     arst_n_i,
  input  logic     tms_i,
  input  logic     tdi_i,
  output logic     tdo_o,
  output logic     dmi_req_valid_o,
  output dmi_req_t dmi_req_o,
  input  logic     dmi_rsp_valid_i,
  input  dmi_rsp_t dmi_rsp_i
);

  localparam int unsigned DmiW = $bits(dmi_req_t);

  typedef enum logic [3:0] {
    TestLogicReset, RunTestIdle, SelectDrScan, CaptureDr,
    ShiftDr, Exit1Dr, PauseDr, Exit2Dr, UpdateDr,
    SelectIrScan, CaptureIr, ShiftIr, Exit1Ir, PauseIr, Exit2Ir, UpdateIr
  } tap_state_e;

  tap_state_e          state_q, state_d;
  logic [IrLength-1:0] ir_sr, ir_q;
  logic [DmiW-1:0]     dr_q;
  dmi_rsp_t            rsp_q;

  ////////////////////
  // TAP controller
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      TestLogicReset: state_d = tms_i ? TestLogicReset : RunTestIdle;
      RunTestIdle:    state_d = tms_i ? SelectDrScan : RunTestIdle;
      SelectDrScan:   state_d = tms_i ? SelectIrScan : CaptureDr;
      CaptureDr:      state_d = tms_i ? Exit1Dr : ShiftDr;
      ShiftDr:        state_d = tms_i ? Exit1Dr : ShiftDr;
      Exit1Dr:        state_d = tms_i ? UpdateDr : PauseDr;
      PauseDr:        state_d = tms_i ? Exit2Dr : PauseDr;
      Exit2Dr:        state_d = tms_i ? UpdateDr : ShiftDr;
      UpdateDr:       state_d = tms_i ? SelectDrScan : RunTestIdle;
      SelectIrScan:   state_d = tms_i ? TestLogicReset : CaptureIr;
      CaptureIr:      state_d = tms_i ? Exit1Ir : ShiftIr;
      ShiftIr:        state_d = tms_i ? Exit1Ir : ShiftIr;
      Exit1Ir:        state_d = tms_i ? UpdateIr : PauseIr;
      PauseIr:        state_d = tms_i ? Exit2Ir : PauseIr;
      Exit2Ir:        state_d = tms_i ? UpdateIr : ShiftIr;
      UpdateIr:       state_d = tms_i ? SelectDrScan : RunTestIdle;
      default:        state_d = TestLogicReset;
    endcase
  end

  always_ff @(posedge jtag_tck or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= TestLogicReset;
      ir_q    <= IrIdcode;
    end else begin
      state_q <= state_d;
      if (state_q == TestLogicReset) begin
        ir_q <= IrIdcode;
      end else if (state_q == UpdateIr) begin
        ir_q <= ir_sr;
      end
    end
  end

  // Instruction shift register, capture pattern ends in 01
  always_ff @(posedge jtag_tck) begin
    if (state_q == CaptureIr) begin
      ir_sr <= IrLength'(1);
    end else if (state_q == ShiftIr) begin
      ir_sr <= {tdi_i, ir_sr[IrLength-1:1]};
    end
  end

  ////////////////////
  // Data registers
  ////////////////////

  // One shift register serves IDCODE, DMI and BYPASS, LSB first
  always_ff @(posedge jtag_tck) begin
    if (state_q == CaptureDr) begin
      case (ir_q)
        IrIdcode: dr_q <= {{(DmiW - 32){1'b0}}, IdCode};
        IrDmi:    dr_q <= {7'b0, rsp_q};
        default:  dr_q <= '0;
      endcase
    end else if (state_q == ShiftDr) begin
      case (ir_q)
        IrIdcode: dr_q <= {{(DmiW - 32){1'b0}}, tdi_i, dr_q[31:1]};
        IrDmi:    dr_q <= {tdi_i, dr_q[DmiW-1:1]};
        default:  dr_q <= {{(DmiW - 1){1'b0}}, tdi_i};
      endcase
    end
  end

  // Latest DMI response, picked up at the next Capture-DR
  always_ff @(posedge jtag_tck or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_q <= '0;
    end else if (dmi_rsp_valid_i) begin
      rsp_q <= dmi_rsp_i;
    end
  end

  assign dmi_req_valid_o = (state_q == UpdateDr) && (ir_q == IrDmi);
  assign dmi_req_o       = dmi_req_t'(dr_q);

  // TDO launched on the falling edge
  always_ff @(negedge jtag_tck or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tdo_o <= 1'b0;
    end else if (state_q == ShiftIr) begin
      tdo_o <= ir_sr[0];
    end else if (state_q == ShiftDr) begin
      tdo_o <= dr_q[0];
    end else begin
      tdo_o <= 1'b0;
    end
  end

endmodule

/* chimera_dbg_pkg.sv */
package chimera_dbg_pkg;

  // DMI operation on request, status on response
  typedef enum logic [1:0] {
    DmiNop   = 2'd0,
    DmiRead  = 2'd1,
    DmiWrite = 2'd2,
    DmiBusy  = 2'd3
  } dmi_op_e;

  localparam dmi_op_e DmiSuccess = DmiNop;

  typedef struct packed {
    logic [6:0]  addr;
    logic [31:0] data;
    dmi_op_e     op;
  } dmi_req_t;

  typedef struct packed {
    logic [31:0] data;
    dmi_op_e     resp;
  } dmi_rsp_t;

  // SBCS layout as seen on the DMI, unused fields read as zero
  typedef struct packed {
    logic [9:0]  zero1;
    logic        sbbusy;
    logic        sbreadonaddr;
    logic [2:0]  sbaccess;
    logic        sbautoincrement;
    logic        sbreadondata;
    logic [2:0]  sberror;
    logic [11:0] zero0;
  } sbcs_t;

  typedef union packed {
    logic [31:0] raw;
    sbcs_t       sbcs;
  } dmi_word_u;

  typedef struct packed {
    logic        we;
    logic [29:0] addr;
    logic [31:0] wdata;
  } sb_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } sb_rsp_t;

  ////////////////////
  // Register map and IR codes
  ////////////////////

  localparam logic [6:0] DmiAddrDmControl  = 7'h10;
  localparam logic [6:0] DmiAddrSbcs       = 7'h38;
  localparam logic [6:0] DmiAddrSbAddress0 = 7'h39;
  localparam logic [6:0] DmiAddrSbData0    = 7'h3C;

  localparam int unsigned IrLength = 5;

  localparam logic [IrLength-1:0] IrIdcode = 5'h01;
  localparam logic [IrLength-1:0] IrDmi    = 5'h11;
  localparam logic [IrLength-1:0] IrBypass = 5'h1F;

  localparam logic [2:0] SberrNone    = 3'd0;
  localparam logic [2:0] SberrBadAddr = 3'd2;
  localparam logic [2:0] SberrBadSize = 3'd4;

  // Only 32-bit accesses are supported
  localparam logic [2:0] SbAccess32 = 3'd2;

endpackage
